//--- design/rv32_isa_pkg.sv
package rv32_isa_pkg;

  // Data and address width
  localparam int WORD_W = 32;

  // ALU operation codes
  localparam int ALUOP_W = 4;

  localparam logic [ALUOP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALUOP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALUOP_W-1:0] ALU_SLL  = 4'd2;
  localparam logic [ALUOP_W-1:0] ALU_SRL  = 4'd3;
  localparam logic [ALUOP_W-1:0] ALU_SRA  = 4'd4;
  localparam logic [ALUOP_W-1:0] ALU_AND  = 4'd5;
  localparam logic [ALUOP_W-1:0] ALU_OR   = 4'd6;
  localparam logic [ALUOP_W-1:0] ALU_XOR  = 4'd7;
  localparam logic [ALUOP_W-1:0] ALU_SLT  = 4'd8;
  localparam logic [ALUOP_W-1:0] ALU_SLTU = 4'd9;

  // Width of the funct3 field
  localparam int FUNCT3_W = 3;

  // Load and store sizes, same as funct3
  localparam logic [FUNCT3_W-1:0] LD_B  = 3'd0;
  localparam logic [FUNCT3_W-1:0] LD_H  = 3'd1;
  localparam logic [FUNCT3_W-1:0] LD_W  = 3'd2;
  localparam logic [FUNCT3_W-1:0] LD_BU = 3'd4;
  localparam logic [FUNCT3_W-1:0] LD_HU = 3'd5;

  // Branch conditions, same as funct3
  localparam logic [FUNCT3_W-1:0] BR_EQ  = 3'd0;
  localparam logic [FUNCT3_W-1:0] BR_NE  = 3'd1;
  localparam logic [FUNCT3_W-1:0] BR_LT  = 3'd4;
  localparam logic [FUNCT3_W-1:0] BR_GE  = 3'd5;
  localparam logic [FUNCT3_W-1:0] BR_LTU = 3'd6;
  localparam logic [FUNCT3_W-1:0] BR_GEU = 3'd7;

endpackage

//--- design/ex_stage_pkg.sv
package ex_stage_pkg;

  // Forwarding selects
  localparam int FWD_SEL_W = 2;

  localparam logic [FWD_SEL_W-1:0] FWD_NONE = 2'd0;
  localparam logic [FWD_SEL_W-1:0] FWD_M    = 2'd1;
  localparam logic [FWD_SEL_W-1:0] FWD_W    = 2'd2;

  // Operand A choices
  localparam int A_SEL_W = 1;

  localparam logic [A_SEL_W-1:0] A_RS1 = 1'b0;
  localparam logic [A_SEL_W-1:0] A_PC  = 1'b1;

  // Operand B choices
  localparam int B_SEL_W = 2;

  localparam logic [B_SEL_W-1:0] B_RS1 = 2'd0;
  localparam logic [B_SEL_W-1:0] B_RS2 = 2'd1;
  localparam logic [B_SEL_W-1:0] B_IMM = 2'd2;

  // One enable per byte lane of a word
  localparam int BE_W = 4;

  localparam int REG_ADDR_W = 5;

endpackage

//--- design/operand_if.sv
`timescale 1ns/1ps

interface operand_if;

  // Forwarded register values
  logic [rv32_isa_pkg::WORD_W-1:0] rs1_val;
  logic [rv32_isa_pkg::WORD_W-1:0] rs2_val;

  // Selected ALU operands
  logic [rv32_isa_pkg::WORD_W-1:0] alu_a;
  logic [rv32_isa_pkg::WORD_W-1:0] alu_b;

  modport bypass (output rs1_val, output rs2_val, output alu_a, output alu_b);

  modport alu (input alu_a, input alu_b);

  modport resolve (input rs1_val, input rs2_val);

endinterface

//--- design/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
  input  logic [ex_stage_pkg::FWD_SEL_W-1:0] bypass_rs1,
  input  logic [ex_stage_pkg::FWD_SEL_W-1:0] bypass_rs2,
  input  logic [rv32_isa_pkg::WORD_W-1:0]    rs1_data,
  input  logic [rv32_isa_pkg::WORD_W-1:0]    rs2_data,
  input  logic [rv32_isa_pkg::WORD_W-1:0]    rd_data_mem,
  input  logic [rv32_isa_pkg::WORD_W-1:0]    rd_data_wb,
  input  logic [rv32_isa_pkg::WORD_W-1:0]    pc,
  input  logic [rv32_isa_pkg::WORD_W-1:0]    imm,
  input  logic [ex_stage_pkg::A_SEL_W-1:0]   alu_a_sel,
  input  logic [ex_stage_pkg::B_SEL_W-1:0]   alu_b_sel,
  operand_if.bypass                          ops
);

  import rv32_isa_pkg::*;
  import ex_stage_pkg::*;

  // Newest value wins: memory stage, then writeback, then register file
  function automatic logic [WORD_W-1:0] fwd_pick(
    input logic [FWD_SEL_W-1:0] sel,
    input logic [WORD_W-1:0]    reg_val
  );
    if (sel == FWD_M) begin
      return rd_data_mem;
    end else if (sel == FWD_W) begin
      return rd_data_wb;
    end
    return reg_val;
  endfunction

  assign ops.rs1_val = fwd_pick(bypass_rs1, rs1_data);
  assign ops.rs2_val = fwd_pick(bypass_rs2, rs2_data);

  always_comb begin
    case (alu_a_sel)
      A_RS1:   ops.alu_a = ops.rs1_val;
      default: ops.alu_a = pc;
    endcase
  end

  always_comb begin
    case (alu_b_sel)
      B_RS1:   ops.alu_b = ops.rs1_val;
      B_RS2:   ops.alu_b = ops.rs2_val;
      B_IMM:   ops.alu_b = imm;
      default: ops.alu_b = '0;
    endcase
  end

endmodule

//--- design/int_alu.sv
`timescale 1ns/1ps

module int_alu (
  operand_if.alu                            ops,
  input  logic [rv32_isa_pkg::ALUOP_W-1:0]  aluop,
  output logic [rv32_isa_pkg::WORD_W-1:0]   result
);

  import rv32_isa_pkg::*;

  logic [4:0] shamt;

  // Shift amount is only the low five bits
  assign shamt = ops.alu_b[4:0];

  always_comb begin
    case (aluop)
      ALU_ADD:  result = ops.alu_a + ops.alu_b;
      ALU_SUB:  result = ops.alu_a - ops.alu_b;
      ALU_SLL:  result = ops.alu_a << shamt;
      ALU_SRL:  result = ops.alu_a >> shamt;
      ALU_SRA:  result = $signed(ops.alu_a) >>> shamt;
      ALU_AND:  result = ops.alu_a & ops.alu_b;
      ALU_OR:   result = ops.alu_a | ops.alu_b;
      ALU_XOR:  result = ops.alu_a ^ ops.alu_b;
      // Compares give 1 or 0
      ALU_SLT: begin
        result = {{(WORD_W-1){1'b0}}, $signed(ops.alu_a) < $signed(ops.alu_b)};
      end
      ALU_SLTU: begin
        result = {{(WORD_W-1){1'b0}}, ops.alu_a < ops.alu_b};
      end
      default:  result = '0;
    endcase
  end

endmodule

//--- design/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
  operand_if.resolve                         ops,
  input  logic [rv32_isa_pkg::WORD_W-1:0]    pc,
  input  logic [rv32_isa_pkg::WORD_W-1:0]    br_imm,
  input  logic [rv32_isa_pkg::WORD_W-1:0]    j_offset,
  input  logic [rv32_isa_pkg::FUNCT3_W-1:0]  branch_type,
  input  logic                               j_sel,
  output logic                               branch_taken,
  output logic [rv32_isa_pkg::WORD_W-1:0]    jump_addr,
  output logic [rv32_isa_pkg::WORD_W-1:0]    resolved_addr
);

  import rv32_isa_pkg::*;

  logic [WORD_W-1:0] pc4;
  logic [WORD_W-1:0] branch_addr;
  logic [WORD_W-1:0] jalr_sum;
  logic              lt_s;
  logic              lt_u;
  logic              eq;

  assign eq   = ops.rs1_val == ops.rs2_val;
  assign lt_s = $signed(ops.rs1_val) < $signed(ops.rs2_val);
  assign lt_u = ops.rs1_val < ops.rs2_val;

  always_comb begin
    case (branch_type)
      BR_EQ:   branch_taken = eq;
      BR_NE:   branch_taken = ~eq;
      BR_LT:   branch_taken = lt_s;
      BR_GE:   branch_taken = ~lt_s;
      BR_LTU:  branch_taken = lt_u;
      BR_GEU:  branch_taken = ~lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

  assign pc4         = pc + WORD_W'(4);
  assign branch_addr = pc + br_imm;

  // Fall through to the next instruction when not taken
  assign resolved_addr = branch_taken ? branch_addr : pc4;

  // JALR target has bit 0 cleared
  assign jalr_sum  = ops.rs1_val + j_offset;
  assign jump_addr = j_sel ? (pc + j_offset) : {jalr_sum[WORD_W-1:1], 1'b0};

endmodule

//--- design/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg (
  input  logic                                CLK,
  input  logic                                nRST,
  input  logic                                halt,
  input  logic                                pc_en,
  input  logic                                ex_mem_flush,
  input  logic                                dmem_access,
  input  logic                                dmem_busy,
  input  logic [rv32_isa_pkg::WORD_W-1:0]     alu_result,
  input  logic [rv32_isa_pkg::WORD_W-1:0]     store_data,
  input  logic [rv32_isa_pkg::WORD_W-1:0]     jump_addr_in,
  input  logic [rv32_isa_pkg::WORD_W-1:0]     resolved_addr_in,
  input  logic [rv32_isa_pkg::FUNCT3_W-1:0]   load_type,
  input  logic                                wen,
  input  logic                                dren,
  input  logic                                dwen,
  input  logic                                jump_instr,
  input  logic                                branch_instr,
  input  logic                                branch_taken_in,
  input  logic [ex_stage_pkg::REG_ADDR_W-1:0] reg_rd,
  output logic [rv32_isa_pkg::WORD_W-1:0]     alu_result_out,
  output logic [rv32_isa_pkg::WORD_W-1:0]     store_data_out,
  output logic [rv32_isa_pkg::WORD_W-1:0]     jump_addr_out,
  output logic [rv32_isa_pkg::WORD_W-1:0]     resolved_addr_out,
  output logic                                mem_wen,
  output logic                                mem_dren,
  output logic                                mem_dwen,
  output logic                                jump_instr_out,
  output logic                                branch_instr_out,
  output logic                                branch_taken_out,
  output logic [ex_stage_pkg::REG_ADDR_W-1:0] reg_rd_out,
  output logic [ex_stage_pkg::BE_W-1:0]       byte_en
);

  import rv32_isa_pkg::*;
  import ex_stage_pkg::*;

  logic [1:0]      byte_offset;
  logic [BE_W-1:0] byte_en_d;
  logic            clear;
  logic            drain;

  // Byte lane comes from the low address bits
  assign byte_offset = alu_result[1:0];

  always_comb begin
    case (load_type)
      LD_B, LD_BU: byte_en_d = BE_W'(1) << byte_offset;
      LD_H, LD_HU: begin
        case (byte_offset)
          2'b00:   byte_en_d = 4'b0011;
          2'b10:   byte_en_d = 4'b1100;
          default: byte_en_d = '0;
        endcase
      end
      LD_W:        byte_en_d = '1;
      default:     byte_en_d = '0;
    endcase
  end

  assign clear = halt | (ex_mem_flush & pc_en);
  // Memory has accepted the request, so drop it
  assign drain = dmem_access & ~dmem_busy;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      alu_result_out    <= '0;
      store_data_out    <= '0;
      jump_addr_out     <= '0;
      resolved_addr_out <= '0;
      mem_wen           <= 1'b0;
      mem_dren          <= 1'b0;
      mem_dwen          <= 1'b0;
      jump_instr_out    <= 1'b0;
      branch_instr_out  <= 1'b0;
      branch_taken_out  <= 1'b0;
      reg_rd_out        <= '0;
      byte_en           <= '0;
    end else if (clear) begin
      alu_result_out    <= '0;
      store_data_out    <= '0;
      jump_addr_out     <= '0;
      resolved_addr_out <= '0;
      mem_wen           <= 1'b0;
      mem_dren          <= 1'b0;
      mem_dwen          <= 1'b0;
      jump_instr_out    <= 1'b0;
      branch_instr_out  <= 1'b0;
      branch_taken_out  <= 1'b0;
      reg_rd_out        <= '0;
      byte_en           <= '0;
    end else if (drain) begin
      mem_dren <= 1'b0;
      mem_dwen <= 1'b0;
    end else if (pc_en) begin
      alu_result_out    <= alu_result;
      store_data_out    <= store_data;
      jump_addr_out     <= jump_addr_in;
      resolved_addr_out <= resolved_addr_in;
      mem_wen           <= wen;
      mem_dren          <= dren;
      mem_dwen          <= dwen;
      jump_instr_out    <= jump_instr;
      branch_instr_out  <= branch_instr;
      branch_taken_out  <= branch_taken_in;
      reg_rd_out        <= reg_rd;
      byte_en           <= byte_en_d;
    end
  end

endmodule

//--- design/ex_stage_top.sv
`timescale 1ns/1ps

module ex_stage_top (
  input  logic                                 CLK,
  input  logic                                 nRST,
  input  logic                                 halt,
  input  logic                                 pc_en,
  input  logic                                 ex_mem_flush,
  input  logic                                 dmem_access,
  input  logic                                 dmem_busy,
  input  logic [rv32_isa_pkg::WORD_W-1:0]      pc,
  input  logic [rv32_isa_pkg::WORD_W-1:0]      rs1_data,
  input  logic [rv32_isa_pkg::WORD_W-1:0]      rs2_data,
  input  logic [rv32_isa_pkg::WORD_W-1:0]      imm,
  input  logic [rv32_isa_pkg::WORD_W-1:0]      br_imm,
  input  logic [rv32_isa_pkg::WORD_W-1:0]      j_offset,
  input  logic [rv32_isa_pkg::WORD_W-1:0]      rd_data_mem,
  input  logic [rv32_isa_pkg::WORD_W-1:0]      rd_data_wb,
  input  logic [ex_stage_pkg::FWD_SEL_W-1:0]   bypass_rs1,
  input  logic [ex_stage_pkg::FWD_SEL_W-1:0]   bypass_rs2,
  input  logic [ex_stage_pkg::A_SEL_W-1:0]     alu_a_sel,
  input  logic [ex_stage_pkg::B_SEL_W-1:0]     alu_b_sel,
  input  logic [rv32_isa_pkg::ALUOP_W-1:0]     aluop,
  input  logic [rv32_isa_pkg::FUNCT3_W-1:0]    branch_type,
  input  logic                                 j_sel,
  input  logic [rv32_isa_pkg::FUNCT3_W-1:0]    load_type,
  input  logic                                 wen,
  input  logic                                 dren,
  input  logic                                 dwen,
  input  logic                                 jump_instr,
  input  logic                                 branch_instr,
  input  logic [ex_stage_pkg::REG_ADDR_W-1:0]  reg_rd,
  output logic [rv32_isa_pkg::WORD_W-1:0]      alu_result_out,
  output logic [rv32_isa_pkg::WORD_W-1:0]      store_wdata,
  output logic                                 mem_wen,
  output logic                                 mem_dren,
  output logic                                 mem_dwen,
  output logic [ex_stage_pkg::BE_W-1:0]        byte_en,
  output logic [rv32_isa_pkg::WORD_W-1:0]      jump_addr,
  output logic                                 jump_instr_out,
  output logic                                 branch_instr_out,
  output logic                                 branch_taken,
  output logic [rv32_isa_pkg::WORD_W-1:0]      br_resolved_addr,
  output logic [ex_stage_pkg::REG_ADDR_W-1:0]  reg_rd_out
);

  import rv32_isa_pkg::*;

  logic [WORD_W-1:0] alu_result;
  logic [WORD_W-1:0] jump_addr_c;
  logic [WORD_W-1:0] resolved_addr_c;
  logic              branch_taken_c;

  operand_if ops ();

  operand_bypass u_operand_bypass (
    .bypass_rs1  (bypass_rs1),
    .bypass_rs2  (bypass_rs2),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rd_data_mem (rd_data_mem),
    .rd_data_wb  (rd_data_wb),
    .pc          (pc),
    .imm         (imm),
    .alu_a_sel   (alu_a_sel),
    .alu_b_sel   (alu_b_sel),
    .ops         (ops)
  );

  int_alu u_int_alu (
    .ops    (ops),
    .aluop  (aluop),
    .result (alu_result)
  );

  branch_resolve u_branch_resolve (
    .ops           (ops),
    .pc            (pc),
    .br_imm        (br_imm),
    .j_offset      (j_offset),
    .branch_type   (branch_type),
    .j_sel         (j_sel),
    .branch_taken  (branch_taken_c),
    .jump_addr     (jump_addr_c),
    .resolved_addr (resolved_addr_c)
  );

  // Store data is the forwarded rs2 value
  ex_mem_reg u_ex_mem_reg (
    .CLK               (CLK),
    .nRST              (nRST),
    .halt              (halt),
    .pc_en             (pc_en),
    .ex_mem_flush      (ex_mem_flush),
    .dmem_access       (dmem_access),
    .dmem_busy         (dmem_busy),
    .alu_result        (alu_result),
    .store_data        (ops.rs2_val),
    .jump_addr_in      (jump_addr_c),
    .resolved_addr_in  (resolved_addr_c),
    .load_type         (load_type),
    .wen               (wen),
    .dren              (dren),
    .dwen              (dwen),
    .jump_instr        (jump_instr),
    .branch_instr      (branch_instr),
    .branch_taken_in   (branch_taken_c),
    .reg_rd            (reg_rd),
    .alu_result_out    (alu_result_out),
    .store_data_out    (store_wdata),
    .jump_addr_out     (jump_addr),
    .resolved_addr_out (br_resolved_addr),
    .mem_wen           (mem_wen),
    .mem_dren          (mem_dren),
    .mem_dwen          (mem_dwen),
    .jump_instr_out    (jump_instr_out),
    .branch_instr_out  (branch_instr_out),
    .branch_taken_out  (branch_taken),
    .reg_rd_out        (reg_rd_out),
    .byte_en           (byte_en)
  );

endmodule

//--- verif/ex_stage_sva.sv
`timescale 1ns/1ps

module ex_stage_sva (
  input logic                                CLK,
  input logic                                nRST,
  input logic                                halt,
  input logic                                pc_en,
  input logic                                ex_mem_flush,
  input logic                                dmem_access,
  input logic                                dmem_busy,
  input logic [rv32_isa_pkg::FUNCT3_W-1:0]   load_type,
  input logic [rv32_isa_pkg::WORD_W-1:0]     alu_result_out,
  input logic                                mem_wen,
  input logic                                mem_dren,
  input logic [ex_stage_pkg::REG_ADDR_W-1:0] reg_rd_out,
  input logic [ex_stage_pkg::BE_W-1:0]       byte_en
);

  import rv32_isa_pkg::*;

  logic quiet;

  // No clear and no drain this edge
  assign quiet = !halt && !ex_mem_flush && !(dmem_access && !dmem_busy);

  a_halt_clears: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> !mem_wen)
    else $error("mem_wen set after halt");

  a_stall_holds: assert property (@(posedge CLK) disable iff (!nRST)
    (!pc_en && quiet) |=> ($stable(alu_result_out) && $stable(mem_wen) &&
                           $stable(mem_dren) && $stable(reg_rd_out) && $stable(byte_en)))
    else $error("register changed while stalled");

  a_byte_onehot: assert property (@(posedge CLK) disable iff (!nRST)
    (pc_en && quiet && (load_type == LD_B || load_type == LD_BU)) |=> $onehot(byte_en))
    else $error("byte load without a single byte lane");

endmodule

bind ex_mem_reg ex_stage_sva u_ex_stage_sva (
  .CLK            (CLK),
  .nRST           (nRST),
  .halt           (halt),
  .pc_en          (pc_en),
  .ex_mem_flush   (ex_mem_flush),
  .dmem_access    (dmem_access),
  .dmem_busy      (dmem_busy),
  .load_type      (load_type),
  .alu_result_out (alu_result_out),
  .mem_wen        (mem_wen),
  .mem_dren       (mem_dren),
  .reg_rd_out     (reg_rd_out),
  .byte_en        (byte_en)
);

//--- verif/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;

  import rv32_isa_pkg::*;
  import ex_stage_pkg::*;

  localparam int M_RUN    = 0;
  localparam int M_MEMREQ = 1;
  localparam int M_FLUSH  = 2;
  localparam int M_HALT   = 3;
  localparam int M_DRAIN  = 4;
  localparam int M_STALL  = 5;
  localparam int M_BUSY   = 6;

  typedef struct {
    string       name;
    int          mode;
    logic [3:0]  aluop;
    logic        a_sel;
    logic [1:0]  b_sel;
    logic [1:0]  bp1;
    logic [1:0]  bp2;
    logic [2:0]  ld;
    logic [2:0]  br;
    logic        j_sel;
    logic [2:0]  fix;
    logic [31:0] rs1_v;
    logic [31:0] rs2_v;
    logic [31:0] imm_v;
  } entry_t;

  // Expected contents of the EX/MEM register
  typedef struct {
    logic [31:0] alu;
    logic [31:0] sdata;
    logic [31:0] jaddr;
    logic [31:0] raddr;
    logic        wen;
    logic        dren;
    logic        dwen;
    logic        jin;
    logic        bin;
    logic        bt;
    logic [4:0]  rd;
    logic [3:0]  be;
  } regs_t;

  logic        CLK, nRST, halt, pc_en, ex_mem_flush, dmem_access, dmem_busy;
  logic [31:0] pc, rs1_data, rs2_data, imm, br_imm, j_offset, rd_data_mem, rd_data_wb;
  logic [1:0]  bypass_rs1, bypass_rs2, alu_b_sel;
  logic        alu_a_sel, j_sel, wen, dren, dwen, jump_instr, branch_instr;
  logic [3:0]  aluop;
  logic [2:0]  branch_type, load_type;
  logic [4:0]  reg_rd;
  logic [31:0] alu_result_out, store_wdata, jump_addr, br_resolved_addr;
  logic        mem_wen, mem_dren, mem_dwen, jump_instr_out, branch_instr_out, branch_taken;
  logic [3:0]  byte_en;
  logic [4:0]  reg_rd_out;

  entry_t      tbl[$];
  regs_t       exp_q;
  logic [31:0] lfsr = 32'h3a68;
  int          errors = 0;
  int          checks = 0;
  bit          table_ready = 0;

  ex_stage_top u_ex_stage_top (.*);

  always #4 CLK = ~CLK;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      // One Galois step per bit
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [31:0] fwd_value(input logic [1:0] sel, input logic [31:0] rf);
    if (sel == FWD_M) return rd_data_mem;
    if (sel == FWD_W) return rd_data_wb;
    return rf;
  endfunction

  function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                         input logic [31:0] b);
    logic [63:0] wide;
    wide = {{32{a[31]}}, a} >> b[4:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 32'd1;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return wide[31:0];
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLT:  return {31'd0, signed_less(a, b)};
      ALU_SLTU: return {31'd0, a < b};
      default:  return '0;
    endcase
  endfunction

  function automatic logic [3:0] be_ref(input logic [2:0] lt, input logic [1:0] off);
    if (lt == LD_B || lt == LD_BU) return 4'b0001 << off;
    if (lt == LD_W) return 4'b1111;
    if (lt == LD_H || lt == LD_HU) begin
      if (off == 2'd0) return 4'b0011;
      if (off == 2'd2) return 4'b1100;
    end
    return 4'b0000;
  endfunction

  function automatic logic taken_ref(input logic [2:0] bt, input logic [31:0] a,
                                     input logic [31:0] b);
    case (bt)
      BR_EQ:   return a == b;
      BR_NE:   return a != b;
      BR_LT:   return signed_less(a, b);
      BR_GE:   return !signed_less(a, b);
      BR_LTU:  return a < b;
      BR_GEU:  return !(a < b);
      default: return 1'b0;
    endcase
  endfunction

  // One clock edge of the EX/MEM register on the inputs now applied
  function automatic regs_t model_step(input regs_t s);
    regs_t       n;
    logic [31:0] r1, r2, a, b;
    n  = s;
    r1 = fwd_value(bypass_rs1, rs1_data);
    r2 = fwd_value(bypass_rs2, rs2_data);
    a  = alu_a_sel ? pc : r1;
    b  = (alu_b_sel == B_RS1) ? r1 : (alu_b_sel == B_RS2) ? r2 :
         (alu_b_sel == B_IMM) ? imm : 32'd0;
    if (halt || (ex_mem_flush && pc_en)) begin
      n = '{default: '0};
    end else if (dmem_access && !dmem_busy) begin
      n.dren = 1'b0;
      n.dwen = 1'b0;
    end else if (pc_en) begin
      n.alu   = alu_ref(aluop, a, b);
      n.sdata = r2;
      n.bt    = taken_ref(branch_type, r1, r2);
      n.raddr = n.bt ? pc + br_imm : pc + 32'd4;
      n.jaddr = j_sel ? pc + j_offset : ((r1 + j_offset) & 32'hffff_fffe);
      n.wen   = wen;
      n.dren  = dren;
      n.dwen  = dwen;
      n.jin   = jump_instr;
      n.bin   = branch_instr;
      n.rd    = reg_rd;
      n.be    = be_ref(load_type, n.alu[1:0]);
    end
    return n;
  endfunction

  task automatic check_field(input string tname, input string field,
                             input logic [31:0] e, input logic [31:0] a);
    checks++;
    if (e !== a) begin
      errors++;
      $display("mismatch %s %s expected %h actual %h", tname, field, e, a);
    end
  endtask

  task automatic check_outputs(input string tname);
    check_field(tname, "alu_result_out", exp_q.alu, alu_result_out);
    check_field(tname, "store_wdata", exp_q.sdata, store_wdata);
    check_field(tname, "jump_addr", exp_q.jaddr, jump_addr);
    check_field(tname, "br_resolved_addr", exp_q.raddr, br_resolved_addr);
    check_field(tname, "mem_wen", 32'(exp_q.wen), 32'(mem_wen));
    check_field(tname, "mem_dren", 32'(exp_q.dren), 32'(mem_dren));
    check_field(tname, "mem_dwen", 32'(exp_q.dwen), 32'(mem_dwen));
    check_field(tname, "jump_instr_out", 32'(exp_q.jin), 32'(jump_instr_out));
    check_field(tname, "branch_instr_out", 32'(exp_q.bin), 32'(branch_instr_out));
    check_field(tname, "branch_taken", 32'(exp_q.bt), 32'(branch_taken));
    check_field(tname, "reg_rd_out", 32'(exp_q.rd), 32'(reg_rd_out));
    check_field(tname, "byte_en", 32'(exp_q.be), 32'(byte_en));
  endtask

  function automatic entry_t blank(input string name, input int mode);
    entry_t e;
    e = '{name: name, mode: mode, aluop: ALU_ADD, a_sel: A_RS1, b_sel: B_RS2,
          bp1: FWD_NONE, bp2: FWD_NONE, ld: LD_W, br: BR_EQ, j_sel: 1'b1,
          fix: 3'b000, rs1_v: '0, rs2_v: '0, imm_v: '0};
    return e;
  endfunction

  task automatic build_table();
    entry_t e;
    logic [31:0] edge_a[4] = '{32'd5, 32'd5, 32'h8000_0000, 32'd1};
    logic [31:0] edge_b[4] = '{32'd5, 32'd6, 32'd1, 32'h8000_0000};
    logic [2:0]  brs[6] = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
    logic [2:0]  lds[7] = '{LD_B, LD_H, LD_W, 3'd3, LD_BU, LD_HU, 3'd7};
    // ALU ops over every operand source
    for (int op = 0; op < 10; op++) begin
      for (int s = 0; s < 6; s++) begin
        e = blank($sformatf("alu_op%0d_a%0d_b%0d", op, s / 3, s % 3), M_RUN);
        e.aluop = 4'(op);
        e.a_sel = 1'(s / 3);
        e.b_sel = 2'(s % 3);
        tbl.push_back(e);
      end
    end
    for (int f = 0; f < 9; f++) begin
      e = blank($sformatf("fwd_rs1_%0d_rs2_%0d", f / 3, f % 3), M_RUN);
      e.bp1 = 2'(f / 3);
      e.bp2 = 2'(f % 3);
      tbl.push_back(e);
    end
    // Address is 0x1000 plus the lane offset in the immediate
    foreach (lds[i]) begin
      for (int off = 0; off < 4; off++) begin
        e = blank($sformatf("be_ld%0d_off%0d", lds[i], off), M_RUN);
        e.b_sel = B_IMM;
        e.ld    = lds[i];
        e.fix   = 3'b101;
        e.rs1_v = 32'h1000;
        e.imm_v = 32'(off);
        tbl.push_back(e);
      end
    end
    foreach (brs[i]) begin
      for (int k = 0; k < 4; k++) begin
        e = blank($sformatf("br_type%0d_case%0d", brs[i], k), M_RUN);
        e.br    = brs[i];
        e.fix   = 3'b011;
        e.rs1_v = edge_a[k];
        e.rs2_v = edge_b[k];
        tbl.push_back(e);
      end
    end
    tbl.push_back(blank("jal", M_RUN));
    e = blank("jalr_odd", M_RUN);
    e.j_sel = 1'b0;
    e.fix   = 3'b001;
    e.rs1_v = 32'h0000_2001;
    tbl.push_back(e);
    e.name  = "jalr_even";
    e.rs1_v = 32'h0000_3000;
    tbl.push_back(e);
    tbl.push_back(blank("memreq_a", M_MEMREQ));
    tbl.push_back(blank("stall_hold", M_STALL));
    tbl.push_back(blank("busy_capture", M_BUSY));
    tbl.push_back(blank("drain", M_DRAIN));
    tbl.push_back(blank("memreq_b", M_MEMREQ));
    tbl.push_back(blank("flush", M_FLUSH));
    tbl.push_back(blank("memreq_c", M_MEMREQ));
    tbl.push_back(blank("halt", M_HALT));
    tbl.push_back(blank("resume", M_RUN));
  endtask

  task automatic apply_entry(input entry_t e);
    logic req;
    // Requests are set before a drain so that the drain has something to clear
    req = (e.mode == M_MEMREQ) || (e.mode == M_BUSY);
    rs1_data     <= e.fix[0] ? e.rs1_v : rand_bits(32);
    rs2_data     <= e.fix[1] ? e.rs2_v : rand_bits(32);
    imm          <= e.fix[2] ? e.imm_v : rand_bits(32);
    pc           <= rand_bits(32);
    br_imm       <= rand_bits(32);
    // Even JALR offset so that rs1 sets bit 0 of the sum
    j_offset     <= e.j_sel ? rand_bits(32) : (rand_bits(32) & 32'hffff_fffe);
    rd_data_mem  <= rand_bits(32);
    rd_data_wb   <= rand_bits(32);
    reg_rd       <= 5'(rand_bits(5));
    jump_instr   <= 1'(rand_bits(1));
    branch_instr <= 1'(rand_bits(1));
    wen          <= req ? 1'b1 : 1'(rand_bits(1));
    dren         <= req ? 1'b1 : 1'(rand_bits(1));
    dwen         <= req ? 1'b1 : 1'(rand_bits(1));
    aluop        <= e.aluop;
    alu_a_sel    <= e.a_sel;
    alu_b_sel    <= e.b_sel;
    bypass_rs1   <= e.bp1;
    bypass_rs2   <= e.bp2;
    load_type    <= e.ld;
    branch_type  <= e.br;
    j_sel        <= e.j_sel;
    pc_en        <= (e.mode != M_STALL);
    halt         <= (e.mode == M_HALT);
    ex_mem_flush <= (e.mode == M_FLUSH);
    dmem_access  <= (e.mode == M_DRAIN) || (e.mode == M_BUSY);
    dmem_busy    <= (e.mode == M_BUSY);
  endtask

  initial begin
    CLK = 0;
    nRST <= 1'b0;
    {halt, pc_en, ex_mem_flush, dmem_access, dmem_busy} <= '0;
    {pc, rs1_data, rs2_data, imm, br_imm, j_offset, rd_data_mem, rd_data_wb} <= '0;
    {bypass_rs1, bypass_rs2, alu_a_sel, alu_b_sel, aluop} <= '0;
    {branch_type, j_sel, load_type, wen, dren, dwen, jump_instr, branch_instr} <= '0;
    reg_rd <= '0;
    exp_q = '{default: '0};
    build_table();
    table_ready = 1;
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_outputs("after_reset");
    foreach (tbl[i]) begin
      @(posedge CLK);
      exp_q = model_step(exp_q);
      apply_entry(tbl[i]);
      @(posedge CLK);
      exp_q = model_step(exp_q);
      @(negedge CLK);
      check_outputs(tbl[i].name);
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Two cycles per entry and the reset, plus margin
  initial begin
    wait (table_ready);
    #((tbl.size() * 4 + 20) * 8);
    $display("timeout: the test sequence did not finish in the expected time");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- ex_stage.f
design/rv32_isa_pkg.sv
design/ex_stage_pkg.sv
design/operand_if.sv
design/operand_bypass.sv
design/int_alu.sv
design/branch_resolve.sv
design/ex_mem_reg.sv
design/ex_stage_top.sv
verif/ex_stage_sva.sv
verif/ex_stage_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module ex_stage_tb -f ex_stage.f

sim:
	verilator --binary --timing --assert --top-module ex_stage_tb -f ex_stage.f -o ex_stage_sim
	./obj_dir/ex_stage_sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
